/* hdl/acl_pkg.sv */
`default_nettype none

package acl_pkg;

	typedef logic [7:0]  acl_byte_t;	// One SPI byte
	typedef logic [15:0] acl_axis_t;	// One axis reading, low byte first on the wire
	typedef logic [4:0]  acl_field_t;	// Packed field of one axis
	typedef logic [14:0] acl_sample_t;	// X high, then Y, Z in the low bits
	typedef logic [17:0] wait_count_t;	// Wide enough for the settle wait
	typedef logic [2:0]  byte_index_t;	// Received data byte 0 to 5

	// Sensor instructions
	localparam acl_byte_t CMD_WRITE = 8'h0A;
	localparam acl_byte_t CMD_READ  = 8'h0B;

	// Register addresses and the value that starts measurement
	localparam acl_byte_t REG_POWER_CTL = 8'h2D;
	localparam acl_byte_t MODE_MEASURE  = 8'h02;
	localparam acl_byte_t REG_XDATA_L   = 8'h0E;	// Burst auto-increments from here

	// Waits in clk cycles at 4 MHz
	localparam int POWERUP_CYCLES  = 24000;		// 6 ms
	localparam int SETTLE_CYCLES   = 160000;	// 40 ms
	localparam int INTERVAL_CYCLES = 40000;		// 10 ms

	localparam int SCLK_DIV   = 4;	// clk cycles per sclk period
	localparam int READ_BYTES = 6;	// Data bytes per burst

	// Lowest axis bit kept in the sample, the field runs up to bit 11
	localparam int FIELD_LSB = 7;

endpackage

`default_nettype wire

/* hdl/spi_byte_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One byte transfer between the frame sequencer and the byte shifter
interface spi_byte_if import acl_pkg::*; ();

	logic      start;	// Strobe, tx_byte valid in the same cycle
	acl_byte_t tx_byte;
	logic      done;	// Strobe, rx_byte valid from here to the next done
	acl_byte_t rx_byte;

	modport seq (
		output start,
		output tx_byte,
		input  done,
		input  rx_byte
	);

	modport shifter (
		input  start,
		input  tx_byte,
		output done,
		output rx_byte
	);

endinterface

`default_nettype wire

/* hdl/sclk_phase_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module sclk_phase_gen import acl_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	output logic sclk_rise,
	output logic sclk_fall
);

	logic [1:0] phase;

	// Free running, so every byte lands on the same sclk grid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= 2'd0;
		end else if (phase == 2'(SCLK_DIV - 1)) begin
			phase <= 2'd0;
		end else begin
			phase <= phase + 2'd1;
		end
	end

	// Falling point opens the period, rising point sits half a period later
	assign sclk_fall = (phase == 2'd0);
	assign sclk_rise = (phase == 2'(SCLK_DIV / 2));

endmodule

`default_nettype wire

/* hdl/spi_byte_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_byte_shifter import acl_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sclk_rise,
	input  logic              sclk_fall,
	input  logic              miso,
	output logic              sclk,
	output logic              mosi,
	spi_byte_if.shifter       bus
);

	typedef enum logic [1:0] {
		SH_IDLE,
		SH_ALIGN,	// Byte taken, waiting for the next fall point
		SH_SHIFT
	} shift_state_t;

	shift_state_t state;
	logic [2:0]   bit_cnt;		// Rising edges seen in this byte
	logic         rx_full;		// All eight bits sampled
	acl_byte_t    tx_sr;
	acl_byte_t    rx_sr;
	acl_byte_t    rx_hold;
	logic         load_idle;
	logic         first_bit;
	logic         next_bit;
	logic         chain;

	assign load_idle = (state == SH_IDLE) && bus.start;
	assign first_bit = (state == SH_ALIGN) && sclk_fall;
	assign next_bit  = (state == SH_SHIFT) && sclk_fall && !rx_full;
	assign chain     = bus.done && bus.start;	// Next byte follows without a gap

	// Byte ends on the fall point after the eighth rise
	assign bus.done    = (state == SH_SHIFT) && rx_full && sclk_fall;
	assign bus.rx_byte = bus.done ? rx_sr : rx_hold;

	always_ff @(posedge clk) begin
		if (load_idle) begin
			tx_sr <= bus.tx_byte;
		end else if (chain) begin
			tx_sr <= {bus.tx_byte[6:0], 1'b0};	// MSB goes out right now
		end else if (first_bit || next_bit) begin
			tx_sr <= {tx_sr[6:0], 1'b0};
		end
		if ((state == SH_SHIFT) && sclk_rise)
			rx_sr <= {rx_sr[6:0], miso};		// MSB first
		if (bus.done)
			rx_hold <= rx_sr;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= SH_IDLE;
			bit_cnt <= 3'd0;
			rx_full <= 1'b0;
			sclk    <= 1'b0;
			mosi    <= 1'b0;
		end else begin
			case (state)
				SH_IDLE: begin
					if (bus.start)
						state <= SH_ALIGN;
				end
				SH_ALIGN: begin
					if (sclk_fall)
						state <= SH_SHIFT;
				end
				SH_SHIFT: begin
					if (sclk_rise) begin
						sclk    <= 1'b1;
						bit_cnt <= bit_cnt + 3'd1;	// Wraps back to zero after bit 0
						if (bit_cnt == 3'd7)
							rx_full <= 1'b1;
					end
					if (sclk_fall) begin
						sclk <= 1'b0;
						if (rx_full) begin
							rx_full <= 1'b0;
							if (!bus.start)
								state <= SH_IDLE;
						end
					end
				end
				default: state <= SH_IDLE;
			endcase

			// Mode 0, data changes on the fall point only
			if (first_bit || next_bit)
				mosi <= tx_sr[7];
			else if (chain)
				mosi <= bus.tx_byte[7];
			else if (bus.done)
				mosi <= 1'b0;		// Rest low while idle
		end
	end

endmodule

`default_nettype wire

/* hdl/acl_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module acl_sequencer import acl_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	output logic        cs,
	spi_byte_if.seq     bus,
	output logic        rx_store,
	output byte_index_t rx_index,
	output logic        frame_end
);

	typedef enum logic [2:0] {
		ST_POWERUP,
		ST_WRITE,
		ST_SETTLE,
		ST_READ_CMD,
		ST_READ_DATA,
		ST_INTERVAL
	} seq_state_t;

	seq_state_t  state;
	wait_count_t wait_cnt;
	wait_count_t wait_limit;
	logic        wait_hit;
	logic [3:0]  byte_cnt;		// Bytes issued in the current frame
	logic        kick;			// First start of a frame
	logic        frame_more;
	logic        read_last;

	always_comb begin
		case (state)
			ST_POWERUP: wait_limit = wait_count_t'(POWERUP_CYCLES - 1);
			ST_SETTLE:  wait_limit = wait_count_t'(SETTLE_CYCLES - 1);
			default:    wait_limit = wait_count_t'(INTERVAL_CYCLES - 1);
		endcase
	end

	assign wait_hit  = (wait_cnt == wait_limit);
	assign read_last = (byte_cnt == 4'(2 + READ_BYTES));

	// Whether another byte goes out when the current one is done
	always_comb begin
		case (state)
			ST_WRITE:     frame_more = (byte_cnt != 4'd3);
			ST_READ_CMD:  frame_more = 1'b1;
			ST_READ_DATA: frame_more = !read_last;
			default:      frame_more = 1'b0;
		endcase
	end

	// Next byte is issued in the same cycle as done, so bytes run back to back
	assign bus.start = kick || (bus.done && frame_more);

	always_comb begin
		bus.tx_byte = 8'h00;		// Zero while reading data
		if (state == ST_WRITE) begin
			case (byte_cnt)
				4'd0:    bus.tx_byte = CMD_WRITE;
				4'd1:    bus.tx_byte = REG_POWER_CTL;
				default: bus.tx_byte = MODE_MEASURE;
			endcase
		end else if (state == ST_READ_CMD) begin
			case (byte_cnt)
				4'd0:    bus.tx_byte = CMD_READ;
				4'd1:    bus.tx_byte = REG_XDATA_L;
				default: bus.tx_byte = 8'h00;	// First data byte starts as the address ends
			endcase
		end
	end

	// Data byte k completes while k+3 bytes have been issued
	assign rx_store = bus.done && (state == ST_READ_DATA);
	assign rx_index = byte_index_t'(byte_cnt - 4'd3);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_POWERUP;
			wait_cnt  <= '0;
			byte_cnt  <= 4'd0;
			kick      <= 1'b0;
			cs        <= 1'b1;
			frame_end <= 1'b0;
		end else begin
			kick      <= 1'b0;
			frame_end <= 1'b0;
			if (bus.start)
				byte_cnt <= byte_cnt + 4'd1;

			case (state)
				ST_POWERUP: begin
					if (wait_hit) begin
						cs       <= 1'b0;
						kick     <= 1'b1;
						byte_cnt <= 4'd0;
						state    <= ST_WRITE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				ST_WRITE: begin
					if (bus.done && !frame_more) begin	// Third byte finished
						cs       <= 1'b1;
						wait_cnt <= '0;
						state    <= ST_SETTLE;
					end
				end
				ST_SETTLE, ST_INTERVAL: begin
					if (wait_hit) begin
						cs       <= 1'b0;
						kick     <= 1'b1;
						byte_cnt <= 4'd0;
						state    <= ST_READ_CMD;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				ST_READ_CMD: begin
					if (bus.done && (byte_cnt == 4'd2))
						state <= ST_READ_DATA;
				end
				ST_READ_DATA: begin
					if (bus.done && read_last) begin
						cs        <= 1'b1;
						frame_end <= 1'b1;
						wait_cnt  <= '0;
						state     <= ST_INTERVAL;
					end
				end
				default: state <= ST_POWERUP;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/acl_sample_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module acl_sample_reg import acl_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  acl_byte_t   rx_byte,
	input  logic        rx_store,
	input  byte_index_t rx_index,
	input  logic        frame_end,
	output acl_sample_t sample,
	output logic        sample_valid
);

	acl_axis_t x_axis;
	acl_axis_t y_axis;
	acl_axis_t z_axis;

	// Sign bit plus the four bits below it
	function automatic acl_field_t pack_field(input acl_axis_t axis);
		pack_field = axis[FIELD_LSB + $bits(acl_field_t) - 1 -: $bits(acl_field_t)];
	endfunction

	// Burst order is X low, X high, Y low, Y high, Z low, Z high
	always_ff @(posedge clk) begin
		if (rx_store) begin
			case (rx_index)
				3'd0:    x_axis[7:0]  <= rx_byte;
				3'd1:    x_axis[15:8] <= rx_byte;
				3'd2:    y_axis[7:0]  <= rx_byte;
				3'd3:    y_axis[15:8] <= rx_byte;
				3'd4:    z_axis[7:0]  <= rx_byte;
				3'd5:    z_axis[15:8] <= rx_byte;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample       <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= frame_end;
			if (frame_end)
				sample <= {pack_field(x_axis), pack_field(y_axis), pack_field(z_axis)};
		end
	end

endmodule

`default_nettype wire

/* hdl/acl_spi_top.sv */
`timescale 1ns/1ns
`default_nettype none

module acl_spi_top import acl_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        miso,
	output logic        sclk,
	output logic        mosi,
	output logic        cs,
	output acl_sample_t sample,
	output logic        sample_valid
);

	logic        sclk_rise;
	logic        sclk_fall;
	logic        rx_store;
	byte_index_t rx_index;
	logic        frame_end;

	spi_byte_if i_byte_bus ();

	sclk_phase_gen i_sclk_phase_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.sclk_rise (sclk_rise),
		.sclk_fall (sclk_fall)
	);

	spi_byte_shifter i_spi_byte_shifter (
		.clk       (clk),
		.rst_n     (rst_n),
		.sclk_rise (sclk_rise),
		.sclk_fall (sclk_fall),
		.miso      (miso),
		.sclk      (sclk),
		.mosi      (mosi),
		.bus       (i_byte_bus.shifter)
	);

	acl_sequencer i_acl_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.cs        (cs),
		.bus       (i_byte_bus.seq),
		.rx_store  (rx_store),
		.rx_index  (rx_index),
		.frame_end (frame_end)
	);

	acl_sample_reg i_acl_sample_reg (
		.clk          (clk),
		.rst_n        (rst_n),
		.rx_byte      (i_byte_bus.rx_byte),
		.rx_store     (rx_store),
		.rx_index     (rx_index),
		.frame_end    (frame_end),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 50;	// 100 ns period
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Released on a falling edge, clear of the DUT's active edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verification/acl_sensor_model.sv */
`timescale 1ns/1ns
`default_nettype none

module acl_sensor_model import acl_pkg::*; (
	input  logic        sclk,
	input  logic        mosi,
	input  logic        cs,
	input  logic [47:0] miso_data,		// Burst bytes, byte 0 in the high bits
	output logic        miso,
	output logic [63:0] frame_log,		// mosi bits of the last frame, last bit in bit 0
	output acl_byte_t   frame_rises		// sclk rising edges of the last frame
);

	localparam int CMD_BITS   = 16;
	localparam int FRAME_BITS = CMD_BITS + 8 * READ_BYTES;

	logic [63:0] mosi_sr;
	acl_byte_t   rise_cnt;
	logic        read_frame;	// First byte was the read instruction

	initial begin
		miso        = 1'b0;
		mosi_sr     = '0;
		rise_cnt    = '0;
		read_frame  = 1'b0;
		frame_log   = '0;
		frame_rises = '0;
	end

	// cs rising closes the frame and hands its record to the testbench
	always @(posedge sclk or posedge cs) begin
		if (cs) begin
			frame_log   <= mosi_sr;
			frame_rises <= rise_cnt;
			mosi_sr     <= '0;
			rise_cnt    <= '0;
			read_frame  <= 1'b0;
		end else begin
			mosi_sr  <= {mosi_sr[62:0], mosi};
			rise_cnt <= rise_cnt + 8'd1;
			if (rise_cnt == 8'(CMD_BITS - 1))
				read_frame <= (mosi_sr[14:7] == CMD_READ);
		end
	end

	// Mode 0 slave, next bit goes out on each falling edge
	always @(negedge sclk or posedge cs) begin
		if (cs)
			miso <= 1'b0;
		else if (read_frame && rise_cnt >= CMD_BITS && rise_cnt < FRAME_BITS)
			miso <= miso_data[FRAME_BITS - 1 - rise_cnt];
		else
			miso <= 1'b0;
	end

endmodule

`default_nettype wire

/* verification/acl_spi_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module acl_spi_tb import acl_pkg::*; ();

	localparam int FRAME_ROWS    = 4;
	localparam int RANDOM_SEED   = 19575;
	localparam int FRAME_TIMEOUT = 10 * 8 * SCLK_DIV;	// Longest frame is eight bytes
	localparam int SLACK         = 64;

	logic        clk;
	logic        rst_n;
	logic        miso;
	logic        sclk;
	logic        mosi;
	logic        cs;
	acl_sample_t sample;
	logic        sample_valid;
	logic [47:0] miso_data;
	logic [63:0] frame_log;
	acl_byte_t   frame_rises;

	logic [47:0] frame_data [0:FRAME_ROWS-1];	// Burst bytes of each read frame
	acl_sample_t frame_expect [0:FRAME_ROWS-1];
	int          valid_pulses;
	logic        valid_prev;
	acl_sample_t held_sample;

	tb_clock_gen i_tb_clock_gen (.clk(clk), .rst_n(rst_n));

	acl_sensor_model i_acl_sensor_model (
		.sclk        (sclk),
		.mosi        (mosi),
		.cs          (cs),
		.miso_data   (miso_data),
		.miso        (miso),
		.frame_log   (frame_log),
		.frame_rises (frame_rises)
	);

	acl_spi_top i_acl_spi_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.miso         (miso),
		.sclk         (sclk),
		.mosi         (mosi),
		.cs           (cs),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	// Axis bits 11 down to 7 are the high byte's low nibble and the low byte's MSB
	function automatic acl_field_t axis_field(input acl_byte_t low, input acl_byte_t high);
		axis_field = {high[3:0], low[7]};
	endfunction

	function automatic acl_sample_t expected_sample(input logic [47:0] bytes);
		expected_sample = {axis_field(bytes[47:40], bytes[39:32]),
			axis_field(bytes[31:24], bytes[23:16]), axis_field(bytes[15:8], bytes[7:0])};
	endfunction

	task automatic report_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_byte(input string name, input acl_byte_t expected, actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_sample(input string name, input acl_sample_t expected, actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
			report_failure();
		end
	endtask

	// Sampled on rising edges, where rst_n is stable, then back on a falling edge
	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			if (cycles > 16) begin
				$display("Reset was never released");
				report_failure();
			end
			@(posedge clk);
			cycles++;
		end
		@(negedge clk);
	endtask

	task automatic wait_cs_level(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (cs !== level) begin
			if (cycles >= limit) begin
				$display("cs did not go to %b within %0d cycles", level, limit);
				report_failure();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic wait_sample_valid(output int cycles);
		cycles = 0;
		while (sample_valid !== 1'b1) begin
			if (cycles >= 2 * SCLK_DIV) begin
				$display("No sample_valid pulse after the read frame");
				report_failure();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	// Every cycle checks that sclk idles outside frames, valid lasts one cycle and sample holds
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (cs === 1'b1)
				check_bit("sclk low while cs is high", 1'b0, sclk);
			if (sample_valid === 1'b1) begin
				if (valid_prev) begin
					$display("sample_valid stayed high for more than one cycle");
					report_failure();
				end
				valid_pulses++;
				held_sample = sample;
			end else begin
				check_sample("sample holds between valid pulses", held_sample, sample);
			end
			valid_prev = (sample_valid === 1'b1);
		end
	end

	initial begin
		int          cycles;
		int          gap;
		int unsigned seed;
		int unsigned rnd;
		seed = RANDOM_SEED;
		rnd  = $urandom(seed);
		frame_data[0] = '0;
		frame_data[1] = '1;
		frame_data[2] = {3{8'hAA, 8'h55}};	// Alternating bits
		for (int row = 3; row < FRAME_ROWS; row++) begin
			frame_data[row][47:16] = $urandom;
			frame_data[row][15:0]  = 16'($urandom);
		end
		for (int row = 0; row < FRAME_ROWS; row++)
			frame_expect[row] = expected_sample(frame_data[row]);
		miso_data    = frame_data[0];
		valid_pulses = 0;
		valid_prev   = 1'b0;
		held_sample  = '0;

		wait_reset_release();
		check_bit("cs after reset", 1'b1, cs);
		check_bit("sclk after reset", 1'b0, sclk);
		check_bit("mosi after reset", 1'b0, mosi);
		check_bit("sample_valid after reset", 1'b0, sample_valid);
		check_sample("sample after reset", '0, sample);

		// One rising edge since release has already passed
		wait_cs_level(1'b0, POWERUP_CYCLES + SLACK, cycles);
		if (cycles + 1 < POWERUP_CYCLES) begin
			$display("cs fell %0d cycles after reset, inside the power-up wait", cycles + 1);
			report_failure();
		end
		wait_cs_level(1'b1, FRAME_TIMEOUT, cycles);
		check_byte("write frame byte 0", CMD_WRITE, frame_log[23:16]);
		check_byte("write frame byte 1", REG_POWER_CTL, frame_log[15:8]);
		check_byte("write frame byte 2", MODE_MEASURE, frame_log[7:0]);
		check_byte("write frame sclk rises", 8'd24, frame_rises);

		wait_cs_level(1'b0, SETTLE_CYCLES + SLACK, cycles);
		if (cycles < SETTLE_CYCLES) begin
			$display("Read frame started %0d cycles after the write frame", cycles);
			report_failure();
		end

		for (int row = 0; row < FRAME_ROWS; row++) begin
			wait_cs_level(1'b1, FRAME_TIMEOUT, cycles);
			check_byte($sformatf("row %0d command", row), CMD_READ, frame_log[63:56]);
			check_byte($sformatf("row %0d address", row), REG_XDATA_L, frame_log[55:48]);
			for (int k = 0; k < READ_BYTES; k++)
				check_byte($sformatf("row %0d mosi idle %0d", row, k), 8'h00,
					frame_log[47 - 8 * k -: 8]);
			check_byte($sformatf("row %0d sclk rises", row), 8'd64, frame_rises);

			wait_sample_valid(gap);
			check_sample($sformatf("row %0d sample", row), frame_expect[row], sample);
			if (row + 1 < FRAME_ROWS)
				miso_data = frame_data[row + 1];
			@(negedge clk);
			gap++;
			if (valid_pulses != row + 1) begin
				$display("Expected %0d sample_valid pulses, saw %0d", row + 1, valid_pulses);
				report_failure();
			end

			if (row + 1 < FRAME_ROWS) begin
				wait_cs_level(1'b0, INTERVAL_CYCLES + SLACK, cycles);
				gap = gap + cycles;
				if (gap < INTERVAL_CYCLES || gap > INTERVAL_CYCLES + SCLK_DIV) begin
					$display("Gap of %0d cycles between read frames is out of range", gap);
					report_failure();
				end
			end
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
hdl/acl_pkg.sv
hdl/spi_byte_if.sv
hdl/sclk_phase_gen.sv
hdl/spi_byte_shifter.sv
hdl/acl_sequencer.sv
hdl/acl_sample_reg.sv
hdl/acl_spi_top.sv
verification/tb_clock_gen.sv
verification/acl_sensor_model.sv
verification/acl_spi_tb.sv
